/* design/tlv_pkg.sv */
/*
 * TLV stream format shared by every block on the prefix ingress path.
 * Defines the type codes, the packed bus word and the command word view
 * that the input-buffer controller decodes.
 */
`default_nettype none

package tlv_pkg;

  localparam int TLV_DATA_W  = 64;
  localparam int TLV_STRB_W  = TLV_DATA_W / 8;
  localparam int TLV_TYPE_W  = 4;
  localparam int CMD_PSIZE_W = 8;

  ////////////////////
  // stream word

  typedef enum logic [TLV_TYPE_W-1:0] {
    CMD            = 4'h0,
    FRMD_USER_NULL = 4'h1,
    FRMD_USER_PI16 = 4'h2,
    FRMD_USER_PI64 = 4'h3,
    FRMD_USER_VM   = 4'h4,
    DATA_UNK       = 4'h5,
    PFX_STATS      = 4'h6
  } tlv_type_e;

  typedef struct packed {
    tlv_type_e             typen;
    logic                  sot;    // first word of the tlv
    logic                  eot;    // last word of the tlv
    logic [TLV_STRB_W-1:0] tstrb;
    logic [TLV_DATA_W-1:0] tdata;
  } tlv_bus_t;

  ////////////////////
  // command tlv

  typedef enum logic [1:0] {
    NO_PREFIX     = 2'd0,
    PREDET_HUFF   = 2'd1,
    PREDEF_PREFIX = 2'd2,
    USER_PREFIX   = 2'd3
  } pfx_mode_e;

  // layout of the last word of a command tlv
  typedef struct packed {
    logic [TLV_DATA_W-CMD_PSIZE_W-3:0] reserved;
    logic [CMD_PSIZE_W-1:0]            user_prefix_size;
    pfx_mode_e                         prefix_mode;
  } cmd_word_t;

endpackage

`default_nettype wire

/* design/pfx_pkg.sv */
/*
 * Constants and control types of the prefix block statistics engine.
 * The controller drives pfx_ctr_ctl_t and the statistics unit returns
 * the four block sums as one pfx_sums_t.
 */
`default_nettype none

package pfx_pkg;

  localparam int PFX_BLK_WORDS = 128;
  localparam int PFX_NUM_BLKS  = 4;
  localparam int PFX_SUM_W     = 16;
  localparam int PFX_WCNT_W    = $clog2(PFX_BLK_WORDS);
  localparam int PFX_SEL_W     = $clog2(PFX_NUM_BLKS);

  localparam int PFX_IB_DEPTH  = 16;  // input fifo entries
  localparam int PFX_BP_DEPTH  = 8;   // bypass fifo entries

  localparam logic [PFX_WCNT_W-1:0]   PFX_WCNT_LOAD = PFX_WCNT_W'(PFX_BLK_WORDS - 1);
  localparam logic [PFX_SEL_W-1:0]    PFX_LAST_BLK  = PFX_SEL_W'(PFX_NUM_BLKS - 1);
  localparam logic [PFX_NUM_BLKS-1:0] PFX_SLOT_ONE  = PFX_NUM_BLKS'(1);
  localparam logic [PFX_NUM_BLKS-1:0] PFX_SLOT_ALL  = '1;

  typedef logic [PFX_SUM_W-1:0] pfx_sum_t;

  typedef struct packed {
    logic [tlv_pkg::TLV_STRB_W-1:0] vbytes;  // byte enables of the counted word
    logic                           reload;  // block end
    logic [PFX_NUM_BLKS-1:0]        ctr_wr;  // one strobe per slot
    logic [PFX_SEL_W-1:0]           blk_sel;
  } pfx_ctr_ctl_t;

  // slot k sits in bits 16k+15 down to 16k
  typedef pfx_sum_t [PFX_NUM_BLKS-1:0] pfx_sums_t;

endpackage

`default_nettype wire

/* design/tlv_fifo.sv */
/*
 * Synchronous FIFO of TLV words with show-ahead read.
 * The head word is valid on rd_tlv whenever empty is low and is
 * consumed on the clock where rd is high.
 */
`timescale 1ns/10ps
`default_nettype none

module tlv_fifo #(
  parameter int DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr,
  input  tlv_pkg::tlv_bus_t wr_tlv,
  input  logic              rd,
  output tlv_pkg::tlv_bus_t rd_tlv,
  output logic              full,
  output logic              afull,
  output logic              empty,
  output logic              aempty
);

  localparam int AW = $clog2(DEPTH);

  tlv_pkg::tlv_bus_t mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic              wr_en;
  logic              rd_en;

  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_en  = wr & ~full;
  assign rd_en  = rd & ~empty;
  assign rd_tlv = mem[rd_ptr];

  assign full   = (count == (AW+1)'(DEPTH));
  assign afull  = (count >= (AW+1)'(DEPTH - 1));  // one free entry or less
  assign empty  = (count == '0);
  assign aempty = (count <= (AW+1)'(1));

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_tlv;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/pfx_ib_ctrl.sv */
/*
 * Input-buffer controller of the prefix ingress stage.
 * Forwards every non-data TLV to the bypass FIFO and, for frames that ask
 * for a predefined prefix, cuts the data payload into 128-word blocks and
 * drives the byte strobes and slot writes of the statistics unit.
 */
`timescale 1ns/10ps
`default_nettype none

module pfx_ib_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             ib_empty,
  input  logic                             ib_aempty,
  input  tlv_pkg::tlv_bus_t                ib_tlv,
  output logic                             ib_rd,
  input  logic                             bp_full,
  input  logic                             bp_afull,
  output tlv_pkg::tlv_bus_t                bp_tlv,
  output logic                             bp_valid,
  input  logic [pfx_pkg::PFX_NUM_BLKS-1:0] ctr_full,
  output pfx_pkg::pfx_ctr_ctl_t            ctr_ctl
);

  logic                           stall;
  logic                           busy;
  logic                           rd_q;
  logic                           ins_en;
  logic                           cnt_en;
  logic [pfx_pkg::PFX_WCNT_W-1:0] wcnt;
  logic                           rd_data;
  logic                           rd_cnt;
  logic                           eodb;
  tlv_pkg::cmd_word_t             cmd_word;
  tlv_pkg::tlv_bus_t              tlv0;
  logic                           tlv0_valid;
  logic                           tlv0_cnt;
  logic                           tlv0_eodb;
  logic                           fwd;
  logic                           blk_end_q;
  logic                           blk_end_d1;
  logic                           blk_eot_q;
  logic                           blk_eot_d1;
  logic                           wr_eot;
  logic                           blk_last;

  // full slots only block a new frame, a frame in progress fills the rest
  assign stall = bp_full | (bp_afull & bp_valid) | ((|ctr_full) & ~cnt_en);

  // the last stored word is never read on two cycles in a row
  assign ib_rd = ~ib_empty & ~(ib_aempty & rd_q) & ~stall & ~busy;

  assign rd_data  = ib_rd & (ib_tlv.typen == tlv_pkg::DATA_UNK);
  assign rd_cnt   = rd_data & ~ib_tlv.sot & cnt_en;
  assign eodb     = rd_cnt & (ib_tlv.eot | (wcnt == '0));
  assign cmd_word = tlv_pkg::cmd_word_t'(ib_tlv.tdata);
  assign fwd      = tlv0_valid & ~stall;
  assign blk_last = wr_eot | (ctr_ctl.blk_sel == pfx_pkg::PFX_LAST_BLK);

  ////////////////////
  // read stage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q       <= 1'b0;
      ins_en     <= 1'b0;
      cnt_en     <= 1'b0;
      busy       <= 1'b0;
      wcnt       <= pfx_pkg::PFX_WCNT_LOAD;
      tlv0_valid <= 1'b0;
      tlv0_cnt   <= 1'b0;
      tlv0_eodb  <= 1'b0;
    end else begin
      rd_q <= ib_rd;

      if (ib_rd && (ib_tlv.typen == tlv_pkg::CMD) && ib_tlv.eot) begin
        ins_en <= (cmd_word.user_prefix_size == '0) &&
                  ((cmd_word.prefix_mode == tlv_pkg::PREDET_HUFF) ||
                   (cmd_word.prefix_mode == tlv_pkg::PREDEF_PREFIX));
      end

      if (ctr_ctl.reload && blk_last) begin
        cnt_en <= 1'b0;                    // slot 4 written or frame done
      end else if (rd_data && ib_tlv.sot && ins_en) begin
        cnt_en <= 1'b1;
      end

      if (eodb) begin
        busy <= 1'b1;
      end else if (|ctr_ctl.ctr_wr) begin
        busy <= 1'b0;
      end

      if ((rd_data && ib_tlv.sot) || eodb) begin
        wcnt <= pfx_pkg::PFX_WCNT_LOAD;
      end else if (rd_data) begin
        wcnt <= wcnt - 1'b1;
      end

      if (!stall) begin
        tlv0_valid <= ib_rd;               // a stalled word waits in tlv0
      end
      if (ib_rd) begin
        tlv0_cnt  <= rd_cnt;
        tlv0_eodb <= eodb;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ib_rd) begin
      tlv0 <= ib_tlv;
    end
    if (fwd) begin
      bp_tlv <= tlv0;
    end
  end

  ////////////////////
  // output stage and block pipeline

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bp_valid        <= 1'b0;
      blk_end_q       <= 1'b0;
      blk_eot_q       <= 1'b0;
      blk_end_d1      <= 1'b0;
      blk_eot_d1      <= 1'b0;
      wr_eot          <= 1'b0;
      ctr_ctl.vbytes  <= '0;
      ctr_ctl.reload  <= 1'b0;
      ctr_ctl.ctr_wr  <= '0;
      ctr_ctl.blk_sel <= '0;
    end else begin
      bp_valid       <= fwd & (tlv0.typen != tlv_pkg::DATA_UNK);
      ctr_ctl.vbytes <= (fwd & tlv0_cnt) ? tlv0.tstrb : '0;

      blk_end_q      <= fwd & tlv0_eodb;
      blk_eot_q      <= fwd & tlv0.eot;
      blk_end_d1     <= blk_end_q;
      blk_eot_d1     <= blk_eot_q;
      ctr_ctl.reload <= blk_end_d1;
      wr_eot         <= blk_eot_d1;

      // a frame that ends early also fills the later slots
      if (ctr_ctl.reload) begin
        ctr_ctl.ctr_wr <= wr_eot ? (pfx_pkg::PFX_SLOT_ALL << ctr_ctl.blk_sel)
                                 : (pfx_pkg::PFX_SLOT_ONE << ctr_ctl.blk_sel);
      end else begin
        ctr_ctl.ctr_wr <= '0;
      end

      if (rd_data && ib_tlv.sot) begin
        ctr_ctl.blk_sel <= '0;
      end else if (ctr_ctl.reload) begin
        ctr_ctl.blk_sel <= ctr_ctl.blk_sel + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/pfx_blk_stats.sv */
/*
 * Block statistics unit. Adds up the valid bytes of each counted block,
 * parks the block total on reload and copies it into the slots selected
 * by the write strobes. The merger empties all four slots at once.
 */
`timescale 1ns/10ps
`default_nettype none

module pfx_blk_stats (
  input  logic                             clk,
  input  logic                             rst_n,
  input  pfx_pkg::pfx_ctr_ctl_t            ctr_ctl,
  input  logic                             sums_taken,
  output logic [pfx_pkg::PFX_NUM_BLKS-1:0] ctr_full,
  output pfx_pkg::pfx_sums_t               sums,
  output logic                             sums_ready
);

  pfx_pkg::pfx_sum_t run_sum;
  pfx_pkg::pfx_sum_t pend_sum;
  pfx_pkg::pfx_sum_t word_bytes;

  function automatic pfx_pkg::pfx_sum_t popcount(
    input logic [tlv_pkg::TLV_STRB_W-1:0] mask
  );
    pfx_pkg::pfx_sum_t n;
    n = '0;
    for (int i = 0; i < tlv_pkg::TLV_STRB_W; i++) begin
      n = n + mask[i];
    end
    return n;
  endfunction

  assign word_bytes = popcount(ctr_ctl.vbytes);
  assign sums_ready = ctr_full[pfx_pkg::PFX_NUM_BLKS-1];  // last slot closes the set

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_sum  <= '0;
      ctr_full <= '0;
    end else begin
      if (ctr_ctl.reload) begin
        run_sum <= word_bytes;
      end else begin
        run_sum <= run_sum + word_bytes;
      end
      ctr_full <= (ctr_full & ~{pfx_pkg::PFX_NUM_BLKS{sums_taken}}) | ctr_ctl.ctr_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (ctr_ctl.reload) begin
      pend_sum <= run_sum;
    end
    for (int k = 0; k < pfx_pkg::PFX_NUM_BLKS; k++) begin
      if (ctr_ctl.ctr_wr[k]) begin
        sums[k] <= pend_sum;
      end
    end
  end

endmodule

`default_nettype wire

/* design/pfx_out_merge.sv */
/*
 * Output merger. Interleaves the bypass TLVs with the single-word
 * PFX_STATS TLV; a waiting statistics word always goes first.
 * out_full is sampled one cycle ahead of the registered output.
 */
`timescale 1ns/10ps
`default_nettype none

module pfx_out_merge (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               byp_empty,
  input  tlv_pkg::tlv_bus_t  byp_tlv,
  output logic               byp_rd,
  input  pfx_pkg::pfx_sums_t sums,
  input  logic               sums_ready,
  output logic               sums_taken,
  input  logic               out_full,
  output tlv_pkg::tlv_bus_t  out_tlv,
  output logic               out_valid
);

  logic              sel_stats;
  logic              sel_byp;
  tlv_pkg::tlv_bus_t stats_tlv;

  assign sel_stats  = sums_ready & ~out_full;
  assign sel_byp    = ~sums_ready & ~byp_empty & ~out_full;
  assign byp_rd     = sel_byp;
  assign sums_taken = sel_stats;  // slots clear on the same edge

  assign stats_tlv = '{
    typen: tlv_pkg::PFX_STATS,
    sot:   1'b1,
    eot:   1'b1,
    tstrb: '1,
    tdata: sums
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sel_stats | sel_byp;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_stats) begin
      out_tlv <= stats_tlv;
    end else if (sel_byp) begin
      out_tlv <= byp_tlv;
    end
  end

endmodule

`default_nettype wire

/* design/pfx_ingress.sv */
/*
 * Top level of the prefix ingress stage.
 * Input FIFO, controller, bypass FIFO, block statistics and output merger.
 */
`timescale 1ns/10ps
`default_nettype none

module pfx_ingress (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_wr,
  input  tlv_pkg::tlv_bus_t in_tlv,
  output logic              in_full,
  input  logic              out_full,
  output tlv_pkg::tlv_bus_t out_tlv,
  output logic              out_valid
);

  tlv_pkg::tlv_bus_t                ib_tlv;
  logic                             ib_rd;
  logic                             ib_empty;
  logic                             ib_aempty;
  tlv_pkg::tlv_bus_t                bp_tlv;
  logic                             bp_valid;
  logic                             bp_full;
  logic                             bp_afull;
  tlv_pkg::tlv_bus_t                byp_tlv;
  logic                             byp_rd;
  logic                             byp_empty;
  pfx_pkg::pfx_ctr_ctl_t            ctr_ctl;
  logic [pfx_pkg::PFX_NUM_BLKS-1:0] ctr_full;
  pfx_pkg::pfx_sums_t               sums;
  logic                             sums_ready;
  logic                             sums_taken;

  tlv_fifo #(.DEPTH(pfx_pkg::PFX_IB_DEPTH)) in_fifo_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (in_wr),
    .wr_tlv (in_tlv),
    .rd     (ib_rd),
    .rd_tlv (ib_tlv),
    .full   (in_full),
    .afull  (),
    .empty  (ib_empty),
    .aempty (ib_aempty)
  );

  pfx_ib_ctrl ib_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ib_empty  (ib_empty),
    .ib_aempty (ib_aempty),
    .ib_tlv    (ib_tlv),
    .ib_rd     (ib_rd),
    .bp_full   (bp_full),
    .bp_afull  (bp_afull),
    .bp_tlv    (bp_tlv),
    .bp_valid  (bp_valid),
    .ctr_full  (ctr_full),
    .ctr_ctl   (ctr_ctl)
  );

  tlv_fifo #(.DEPTH(pfx_pkg::PFX_BP_DEPTH)) byp_fifo_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (bp_valid),
    .wr_tlv (bp_tlv),
    .rd     (byp_rd),
    .rd_tlv (byp_tlv),
    .full   (bp_full),
    .afull  (bp_afull),
    .empty  (byp_empty),
    .aempty ()
  );

  pfx_blk_stats blk_stats_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctr_ctl    (ctr_ctl),
    .sums_taken (sums_taken),
    .ctr_full   (ctr_full),
    .sums       (sums),
    .sums_ready (sums_ready)
  );

  pfx_out_merge out_merge_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .byp_empty  (byp_empty),
    .byp_tlv    (byp_tlv),
    .byp_rd     (byp_rd),
    .sums       (sums),
    .sums_ready (sums_ready),
    .sums_taken (sums_taken),
    .out_full   (out_full),
    .out_tlv    (out_tlv),
    .out_valid  (out_valid)
  );

endmodule

`default_nettype wire

/* verification/pfx_ingress_model.svh */
/*
 * Reference model of the prefix ingress stage, included inside the testbench.
 * Every word written to the DUT goes through model_word, which queues the
 * expected bypass words and, at the end of an enabled frame, the expected
 * PFX_STATS word.
 */
`ifndef PFX_INGRESS_MODEL_SVH
`define PFX_INGRESS_MODEL_SVH

tlv_pkg::tlv_bus_t exp_byp[$];
tlv_pkg::tlv_bus_t exp_stats[$];
int                blk_bytes[pfx_pkg::PFX_NUM_BLKS];
int                pay_cnt;
logic              mdl_ins_en;

// statistics only for a predefined prefix without a user prefix
function automatic logic stats_wanted(input logic [tlv_pkg::TLV_DATA_W-1:0] last_word);
  tlv_pkg::cmd_word_t cw;
  cw = tlv_pkg::cmd_word_t'(last_word);
  return (cw.user_prefix_size == 8'd0) &&
         ((cw.prefix_mode == tlv_pkg::PREDET_HUFF) ||
          (cw.prefix_mode == tlv_pkg::PREDEF_PREFIX));
endfunction

function automatic tlv_pkg::tlv_bus_t stats_word();
  tlv_pkg::tlv_bus_t  w;
  pfx_pkg::pfx_sums_t s;
  int                 last;
  last = (pay_cnt - 1) / pfx_pkg::PFX_BLK_WORDS;
  for (int k = 0; k < pfx_pkg::PFX_NUM_BLKS; k++) begin
    s[k] = 16'(blk_bytes[(k < last) ? k : last]);  // short frames repeat their last block
  end
  w.typen = tlv_pkg::PFX_STATS;
  w.sot   = 1'b1;
  w.eot   = 1'b1;
  w.tstrb = '1;
  w.tdata = s;
  return w;
endfunction

function automatic void model_word(input tlv_pkg::tlv_bus_t w);
  if (w.typen != tlv_pkg::DATA_UNK) begin
    exp_byp.push_back(w);
    if ((w.typen == tlv_pkg::CMD) && w.eot) begin
      mdl_ins_en = stats_wanted(w.tdata);
    end
  end else if (w.sot) begin
    pay_cnt = 0;  // header word of the data tlv carries no payload
    for (int k = 0; k < pfx_pkg::PFX_NUM_BLKS; k++) begin
      blk_bytes[k] = 0;
    end
  end else begin
    if (pay_cnt / pfx_pkg::PFX_BLK_WORDS < pfx_pkg::PFX_NUM_BLKS) begin
      blk_bytes[pay_cnt / pfx_pkg::PFX_BLK_WORDS] += $countones(w.tstrb);
    end
    pay_cnt++;
    if (w.eot && mdl_ins_en) begin
      exp_stats.push_back(stats_word());
    end
  end
endfunction

`endif

/* verification/pfx_ingress_tb.sv */
/*
 * Testbench of the prefix ingress stage. Random frames go into the input
 * FIFO, a monitor splits the output into bypass and statistics words and
 * each test compares both streams with the reference model.
 */
`timescale 1ns/10ps
`default_nettype none

module pfx_ingress_tb;

  localparam int WAIT_LIMIT = 50000;

  logic              clk;
  logic              rst_n;
  logic              in_wr;
  tlv_pkg::tlv_bus_t in_tlv;
  logic              in_full;
  logic              out_full;
  tlv_pkg::tlv_bus_t out_tlv;
  logic              out_valid;

  integer            seed;
  int                errors;
  int                tests;
  int                test_err0;
  logic              bp_random;  // out_full takes a new random value every cycle
  tlv_pkg::tlv_bus_t got_byp[$];
  tlv_pkg::tlv_bus_t got_stats[$];

  `include "pfx_ingress_model.svh"

  pfx_ingress dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_wr     (in_wr),
    .in_tlv    (in_tlv),
    .in_full   (in_full),
    .out_full  (out_full),
    .out_tlv   (out_tlv),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // registered outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid && (out_tlv.typen == tlv_pkg::PFX_STATS)) begin
        got_stats.push_back(out_tlv);
      end else if (out_valid) begin
        got_byp.push_back(out_tlv);
      end
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic int urand(input int n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (bp_random) begin
      out_full = (urand(2) == 1);
    end
  endtask

  task automatic end_run();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic write_word(input tlv_pkg::tlv_bus_t w);
    int n;
    n = 0;
    while (in_full && (n < WAIT_LIMIT)) begin
      next_cycle();
      n++;
    end
    if (in_full) begin
      $display("input FIFO still full after %0d cycles at %0t", WAIT_LIMIT, $time);
      errors++;
      end_run();
    end else begin
      in_tlv = w;
      in_wr  = 1'b1;
      model_word(w);
      next_cycle();
      in_wr  = 1'b0;
    end
  endtask

  task automatic send_frame(input tlv_pkg::pfx_mode_e mode, input logic [7:0] psize,
                            input int npay);
    tlv_pkg::tlv_bus_t  w;
    tlv_pkg::cmd_word_t cw;
    int                 ncmd;
    int                 nfrmd;
    ncmd  = 1 + urand(3);
    nfrmd = urand(3);
    for (int i = 0; i < ncmd; i++) begin
      w.typen = tlv_pkg::CMD;
      w.sot   = (i == 0);
      w.eot   = (i == ncmd - 1);
      w.tstrb = '1;
      w.tdata = {rand32(), rand32()};
      if (w.eot) begin
        cw                  = tlv_pkg::cmd_word_t'(w.tdata);
        cw.prefix_mode      = mode;
        cw.user_prefix_size = psize;
        w.tdata             = cw;
      end
      write_word(w);
    end
    for (int i = 0; i < nfrmd; i++) begin
      w.typen = tlv_pkg::tlv_type_e'(4'(1 + urand(4)));  // one-word FRMD tlvs
      w.sot   = 1'b1;
      w.eot   = 1'b1;
      w.tdata = {rand32(), rand32()};
      write_word(w);
    end
    w.typen = tlv_pkg::DATA_UNK;
    w.sot   = 1'b1;
    w.eot   = 1'b0;
    write_word(w);
    for (int j = 0; j < npay; j++) begin
      w.sot   = 1'b0;
      w.eot   = (j == npay - 1);
      w.tstrb = 8'(urand(256));
      w.tdata = {rand32(), rand32()};
      write_word(w);
    end
  endtask

  task automatic random_frame();
    logic [7:0] psize;
    psize = (urand(4) == 0) ? 8'(1 + urand(255)) : 8'd0;
    send_frame(tlv_pkg::pfx_mode_e'(2'(urand(4))), psize, 1 + urand(600));
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_err0);
    end
  endtask

  task automatic check_word(input string sig, input int idx, input tlv_pkg::tlv_bus_t got,
                            input tlv_pkg::tlv_bus_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s %0d = %h, expected %h", $time, sig, idx, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle();
    test_err0 = errors;
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      if (out_valid !== 1'b0) begin
        $display("Fail at %0t: out_valid = %b, expected 0", $time, out_valid);
        errors++;
      end
      if (in_full !== 1'b0) begin
        $display("Fail at %0t: in_full = %b, expected 0", $time, in_full);
        errors++;
      end
    end
    report_test("idle_after_reset");
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    while (((got_byp.size() < exp_byp.size()) || (got_stats.size() < exp_stats.size())) &&
           (n < WAIT_LIMIT)) begin
      next_cycle();
      n++;
    end
    if ((got_byp.size() < exp_byp.size()) || (got_stats.size() < exp_stats.size())) begin
      $display("%s: output stopped with %0d of %0d bypass and %0d of %0d statistics words",
               name, got_byp.size(), exp_byp.size(), got_stats.size(), exp_stats.size());
      errors++;
      end_run();
    end else begin
      repeat (50) next_cycle();  // give extra words a chance to appear
      if (got_byp.size() != exp_byp.size()) begin
        $display("Fail at %0t: out_tlv bypass word count = %0d, expected %0d",
                 $time, got_byp.size(), exp_byp.size());
        errors++;
      end
      if (got_stats.size() != exp_stats.size()) begin
        $display("Fail at %0t: out_tlv PFX_STATS count = %0d, expected %0d",
                 $time, got_stats.size(), exp_stats.size());
        errors++;
      end
      for (int i = 0; i < exp_byp.size(); i++) begin
        check_word("out_tlv bypass word", i, got_byp[i], exp_byp[i]);
      end
      for (int i = 0; i < exp_stats.size(); i++) begin
        check_word("out_tlv PFX_STATS word", i, got_stats[i], exp_stats[i]);
      end
      report_test(name);
      got_byp.delete();
      got_stats.delete();
      exp_byp.delete();
      exp_stats.delete();
    end
  endtask

  ////////////////////
  // test sequence

  initial begin
    seed       = 32'h53e59050;
    errors     = 0;
    tests      = 0;
    bp_random  = 1'b0;
    mdl_ins_en = 1'b0;
    pay_cnt    = 0;
    rst_n      = 1'b0;
    in_wr      = 1'b0;
    in_tlv     = '0;
    out_full   = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    check_idle();

    test_err0 = errors;  // 1, 2, 4 and 6 blocks
    send_frame(tlv_pkg::PREDET_HUFF, 8'd0, 1 + urand(128));
    send_frame(tlv_pkg::PREDEF_PREFIX, 8'd0, 129 + urand(128));
    send_frame(tlv_pkg::PREDET_HUFF, 8'd0, 385 + urand(128));
    send_frame(tlv_pkg::PREDEF_PREFIX, 8'd0, 641 + urand(128));
    finish_test("block_stats");

    test_err0 = errors;
    send_frame(tlv_pkg::NO_PREFIX, 8'd0, 1 + urand(600));
    send_frame(tlv_pkg::USER_PREFIX, 8'd0, 1 + urand(600));
    send_frame(tlv_pkg::PREDET_HUFF, 8'd5, 1 + urand(600));
    send_frame(tlv_pkg::PREDEF_PREFIX, 8'(1 + urand(255)), 1 + urand(600));
    finish_test("stats_disabled");

    test_err0 = errors;
    repeat (6) random_frame();
    finish_test("bypass_order");

    test_err0 = errors;
    bp_random = 1'b1;
    repeat (8) random_frame();
    finish_test("back_pressure");
    end_run();
  end

endmodule

`default_nettype wire

/* pfx_ingress.f */
+incdir+verification
design/tlv_pkg.sv
design/pfx_pkg.sv
design/tlv_fifo.sv
design/pfx_ib_ctrl.sv
design/pfx_blk_stats.sv
design/pfx_out_merge.sv
design/pfx_ingress.sv
verification/pfx_ingress_tb.sv
